//--- design/scb_cfg_pkg.sv
package scb_cfg_pkg;

    // sid index width, window of 8 in flight
    localparam int SID_W     = 3;
    localparam int NUM_SLOTS = 4;

    typedef logic [4:0] reg_idx_t;

    // wrap bit on top of the index
    typedef logic [SID_W:0] sid_t;

    typedef logic [NUM_SLOTS-1:0] slot_mask_t;

    typedef enum logic [1:0] {
        SLOT_ALU0,
        SLOT_ALU1,
        SLOT_BEU,
        SLOT_LSU
    } slot_id_e;

    typedef enum logic [1:0] {
        UNIT_NONE,
        UNIT_ALU,
        UNIT_BEU,
        UNIT_LSU
    } unit_e;

    // true when a is younger than b
    function automatic logic is_younger(sid_t a, sid_t b);
        if (a[SID_W] == b[SID_W]) begin
            return a[SID_W-1:0] > b[SID_W-1:0];
        end
        // index wrapped between a and b
        return a[SID_W-1:0] < b[SID_W-1:0];
    endfunction

endpackage

//--- design/scb_msg_pkg.sv
package scb_msg_pkg;

    import scb_cfg_pkg::*;

    typedef struct packed {
        logic     vld;
        unit_e    unit;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } dec_lane_t;

    typedef struct packed {
        logic     vld;
        sid_t     sid;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
    } op_lane_t;

    typedef struct packed {
        logic     vld;
        sid_t     sid;
        reg_idx_t rd;
    } wb_lane_t;

    typedef struct packed {
        logic vld;
        sid_t sid;
    } redirect_t;

    typedef struct packed {
        logic     busy;
        reg_idx_t rd;
        reg_idx_t rs1;
        reg_idx_t rs2;
        sid_t     sid;
    } slot_entry_t;

    typedef slot_entry_t [NUM_SLOTS-1:0] slot_vec_t;

    // one grant bit per slot, all zero when the lane does not issue
    typedef struct packed {
        slot_mask_t grant;
        reg_idx_t   rd;
        reg_idx_t   rs1;
        reg_idx_t   rs2;
        sid_t       sid;
    } alloc_t;

    typedef dec_lane_t [1:0] dec_pair_t;
    typedef op_lane_t  [1:0] op_pair_t;
    typedef wb_lane_t  [1:0] wb_pair_t;
    typedef alloc_t    [1:0] alloc_pair_t;

endpackage

//--- design/issue_ctrl.sv
module issue_ctrl (
    input  logic                          clk,
    input  logic                          rst_n,
    input  scb_msg_pkg::dec_pair_t        dec_i,
    input  scb_msg_pkg::slot_vec_t        slots_i,
    input  scb_msg_pkg::redirect_t        redirect_i,
    output logic [1:0]                    dec_stall_o,
    output logic [1:0]                    dec_flush_o,
    output scb_cfg_pkg::sid_t [1:0]       dec_sid_o,
    output scb_cfg_pkg::slot_mask_t [1:0] dec_grant_o,
    output scb_msg_pkg::alloc_pair_t      alloc_o
);
    import scb_cfg_pkg::*;
    import scb_msg_pkg::*;

    sid_t       sid_cnt_r;
    slot_mask_t busy;
    slot_mask_t grant0;
    slot_mask_t grant1;
    logic       pair_waw;
    logic [1:0] issue;

    // first free slot of the requested class
    function automatic slot_mask_t pick_slot(unit_e unit, slot_mask_t avail);
        slot_mask_t sel;
        sel = '0;
        case (unit)
            UNIT_ALU: begin
                if (avail[SLOT_ALU0]) begin
                    sel[SLOT_ALU0] = 1'b1;
                end else if (avail[SLOT_ALU1]) begin
                    sel[SLOT_ALU1] = 1'b1;
                end
            end
            UNIT_BEU: sel[SLOT_BEU] = avail[SLOT_BEU];
            UNIT_LSU: sel[SLOT_LSU] = avail[SLOT_LSU];
            default:  sel = '0;
        endcase
        return sel;
    endfunction

    // write-after-write against any busy slot
    function automatic logic rd_busy(reg_idx_t rd, slot_vec_t slots);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (slots[i].busy && slots[i].rd == rd) begin
                hit = 1'b1;
            end
        end
        return hit;
    endfunction

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            busy[i] = slots_i[i].busy;
        end
        grant0 = '0;
        grant1 = '0;
        if (dec_i[0].vld && !rd_busy(dec_i[0].rd, slots_i)) begin
            grant0 = pick_slot(dec_i[0].unit, ~busy);
        end
        // lane1 never shares a slot with lane0
        if (dec_i[1].vld && !rd_busy(dec_i[1].rd, slots_i)) begin
            grant1 = pick_slot(dec_i[1].unit, ~busy & ~grant0);
        end
    end

    assign pair_waw = dec_i[0].vld && dec_i[1].vld && (dec_i[0].rd == dec_i[1].rd);

    assign dec_stall_o[0] = dec_i[0].vld && (grant0 == '0);
    assign dec_stall_o[1] = dec_i[1].vld &&
                            ((grant1 == '0) || (dec_i[0].vld && (grant0 == '0)) || pair_waw);

    assign dec_sid_o[0] = sid_cnt_r;
    assign dec_sid_o[1] = sid_cnt_r + sid_t'(1);

    assign dec_flush_o[0] = redirect_i.vld && is_younger(dec_sid_o[0], redirect_i.sid);
    assign dec_flush_o[1] = redirect_i.vld && is_younger(dec_sid_o[1], redirect_i.sid);

    assign issue = {dec_i[1].vld, dec_i[0].vld} & ~dec_stall_o & ~dec_flush_o;

    assign dec_grant_o[0] = issue[0] ? grant0 : '0;
    assign dec_grant_o[1] = issue[1] ? grant1 : '0;

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            alloc_o[l].grant = dec_grant_o[l];
            alloc_o[l].rd    = dec_i[l].rd;
            alloc_o[l].rs1   = dec_i[l].rs1;
            alloc_o[l].rs2   = dec_i[l].rs2;
            alloc_o[l].sid   = dec_sid_o[l];
        end
    end

    // advance by the number of lanes issued
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sid_cnt_r <= '0;
        end else begin
            sid_cnt_r <= sid_cnt_r + sid_t'(issue[0]) + sid_t'(issue[1]);
        end
    end

endmodule

//--- design/slot_table.sv
module slot_table (
    input  logic                     clk,
    input  logic                     rst_n,
    input  scb_msg_pkg::alloc_pair_t alloc_i,
    input  scb_cfg_pkg::slot_mask_t  release_i,
    input  scb_msg_pkg::redirect_t   redirect_i,
    output scb_msg_pkg::slot_vec_t   slots_o
);
    import scb_cfg_pkg::*;
    import scb_msg_pkg::*;

    slot_mask_t busy_r;
    reg_idx_t   rd_r  [NUM_SLOTS];
    reg_idx_t   rs1_r [NUM_SLOTS];
    reg_idx_t   rs2_r [NUM_SLOTS];
    sid_t       sid_r [NUM_SLOTS];
    slot_mask_t flush_hit;

    // busy slots younger than the redirect
    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            flush_hit[i] = busy_r[i] && redirect_i.vld && is_younger(sid_r[i], redirect_i.sid);
        end
    end

    // flush, then lane0, then lane1, then release
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            busy_r <= '0;
        end else begin
            for (int i = 0; i < NUM_SLOTS; i++) begin
                if (flush_hit[i]) begin
                    busy_r[i] <= 1'b0;
                end else if (alloc_i[0].grant[i] || alloc_i[1].grant[i]) begin
                    busy_r[i] <= 1'b1;
                end else if (release_i[i] && busy_r[i]) begin
                    busy_r[i] <= 1'b0;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            if (!flush_hit[i]) begin
                if (alloc_i[0].grant[i]) begin
                    rd_r[i]  <= alloc_i[0].rd;
                    rs1_r[i] <= alloc_i[0].rs1;
                    rs2_r[i] <= alloc_i[0].rs2;
                    sid_r[i] <= alloc_i[0].sid;
                end else if (alloc_i[1].grant[i]) begin
                    rd_r[i]  <= alloc_i[1].rd;
                    rs1_r[i] <= alloc_i[1].rs1;
                    rs2_r[i] <= alloc_i[1].rs2;
                    sid_r[i] <= alloc_i[1].sid;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_SLOTS; i++) begin
            slots_o[i].busy = busy_r[i];
            slots_o[i].rd   = rd_r[i];
            slots_o[i].rs1  = rs1_r[i];
            slots_o[i].rs2  = rs2_r[i];
            slots_o[i].sid  = sid_r[i];
        end
    end

endmodule

//--- design/operand_hazard.sv
module operand_hazard (
    input  scb_msg_pkg::op_pair_t  op_i,
    input  scb_msg_pkg::slot_vec_t slots_i,
    input  scb_msg_pkg::redirect_t redirect_i,
    output logic [1:0]             op_stall_o,
    output logic [1:0]             op_flush_o
);
    import scb_cfg_pkg::*;
    import scb_msg_pkg::*;

    logic [1:0] raw_slot;
    logic [1:0] raw_lane;

    function automatic logic reads(op_lane_t lane, reg_idx_t rd);
        return (lane.rs1 == rd) || (lane.rs2 == rd);
    endfunction

    always_comb begin
        for (int l = 0; l < 2; l++) begin
            raw_slot[l] = 1'b0;
            // only producers older than this lane count
            for (int s = 0; s < NUM_SLOTS; s++) begin
                if (slots_i[s].busy && reads(op_i[l], slots_i[s].rd) &&
                    is_younger(op_i[l].sid, slots_i[s].sid)) begin
                    raw_slot[l] = 1'b1;
                end
            end
            // partner lane as producer
            raw_lane[l] = op_i[1-l].vld && reads(op_i[l], op_i[1-l].rd) &&
                          is_younger(op_i[l].sid, op_i[1-l].sid);
            op_stall_o[l] = op_i[l].vld && (raw_slot[l] || raw_lane[l]);
            op_flush_o[l] = redirect_i.vld && is_younger(op_i[l].sid, redirect_i.sid);
        end
    end

endmodule

//--- design/wb_retire.sv
module wb_retire (
    input  scb_msg_pkg::wb_pair_t   wb_i,
    input  scb_msg_pkg::slot_vec_t  slots_i,
    input  scb_msg_pkg::redirect_t  redirect_i,
    output logic [1:0]              wb_stall_o,
    output logic [1:0]              wb_flush_o,
    output scb_cfg_pkg::slot_mask_t release_o
);
    import scb_cfg_pkg::*;
    import scb_msg_pkg::*;

    logic       same_rd;
    logic [1:0] retire;

    assign same_rd = wb_i[0].vld && wb_i[1].vld && (wb_i[0].rd == wb_i[1].rd);

    // younger writer waits so the register ends with its value
    assign wb_stall_o[0] = same_rd && is_younger(wb_i[0].sid, wb_i[1].sid);
    assign wb_stall_o[1] = same_rd && is_younger(wb_i[1].sid, wb_i[0].sid);

    assign retire[0] = wb_i[0].vld && !wb_stall_o[0];
    assign retire[1] = wb_i[1].vld && !wb_stall_o[1];

    always_comb begin
        for (int s = 0; s < NUM_SLOTS; s++) begin
            release_o[s] = (retire[0] && slots_i[s].sid == wb_i[0].sid) ||
                           (retire[1] && slots_i[s].sid == wb_i[1].sid);
        end
        for (int l = 0; l < 2; l++) begin
            wb_flush_o[l] = redirect_i.vld && is_younger(wb_i[l].sid, redirect_i.sid);
        end
    end

endmodule

//--- design/scoreboard_top.sv
module scoreboard_top (
    input  logic                          clk,
    input  logic                          rst_n,
    // decode
    input  scb_msg_pkg::dec_pair_t        dec_i,
    output logic [1:0]                    dec_stall_o,
    output logic [1:0]                    dec_flush_o,
    output scb_cfg_pkg::sid_t [1:0]       dec_sid_o,
    output scb_cfg_pkg::slot_mask_t [1:0] dec_grant_o,
    // operand read
    input  scb_msg_pkg::op_pair_t         op_i,
    output logic [1:0]                    op_stall_o,
    output logic [1:0]                    op_flush_o,
    // writeback
    input  scb_msg_pkg::wb_pair_t         wb_i,
    output logic [1:0]                    wb_stall_o,
    output logic [1:0]                    wb_flush_o,
    input  scb_msg_pkg::redirect_t        redirect_i
);
    import scb_cfg_pkg::*;
    import scb_msg_pkg::*;

    slot_vec_t   slots;
    alloc_pair_t alloc;
    slot_mask_t  release_mask;

    issue_ctrl u_issue_ctrl (
        .clk         (clk),
        .rst_n       (rst_n),
        .dec_i       (dec_i),
        .slots_i     (slots),
        .redirect_i  (redirect_i),
        .dec_stall_o (dec_stall_o),
        .dec_flush_o (dec_flush_o),
        .dec_sid_o   (dec_sid_o),
        .dec_grant_o (dec_grant_o),
        .alloc_o     (alloc)
    );

    slot_table u_slot_table (
        .clk        (clk),
        .rst_n      (rst_n),
        .alloc_i    (alloc),
        .release_i  (release_mask),
        .redirect_i (redirect_i),
        .slots_o    (slots)
    );

    operand_hazard u_operand_hazard (
        .op_i       (op_i),
        .slots_i    (slots),
        .redirect_i (redirect_i),
        .op_stall_o (op_stall_o),
        .op_flush_o (op_flush_o)
    );

    wb_retire u_wb_retire (
        .wb_i       (wb_i),
        .slots_i    (slots),
        .redirect_i (redirect_i),
        .wb_stall_o (wb_stall_o),
        .wb_flush_o (wb_flush_o),
        .release_o  (release_mask)
    );

endmodule

//--- test/scoreboard_tb.sv
module scoreboard_tb;
    import scb_cfg_pkg::*;
    import scb_msg_pkg::*;

    localparam int CLK_PERIOD = 8;
    // six tests of a 5 cycle reset and at most four cycles each
    localparam int BUDGET_CYCLES = 6 * (5 + 4) + 20;

    logic             clk;
    logic             rst_n;
    dec_pair_t        dec_i;
    op_pair_t         op_i;
    wb_pair_t         wb_i;
    redirect_t        redirect_i;
    logic [1:0]       dec_stall_o;
    logic [1:0]       dec_flush_o;
    logic [1:0]       op_stall_o;
    logic [1:0]       op_flush_o;
    logic [1:0]       wb_stall_o;
    logic [1:0]       wb_flush_o;
    sid_t [1:0]       dec_sid_o;
    slot_mask_t [1:0] dec_grant_o;

    scoreboard_top DUT (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(BUDGET_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", BUDGET_CYCLES);
        $display("TESTBENCH FAILED");
        $fatal(1, "run stopped by watchdog");
    end

    task automatic check(string name, logic [31:0] got, logic [31:0] exp);
        if (got !== exp) begin
            $display("Mismatch %s: got 0x%h, expected 0x%h", name, got, exp);
            $display("TESTBENCH FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    function automatic dec_lane_t dec_lane(unit_e kind, reg_idx_t rd);
        return '{vld: 1'b1, unit: kind, rd: rd, rs1: 5'd0, rs2: 5'd0};
    endfunction

    function automatic op_lane_t op_lane(sid_t sid, reg_idx_t rd, reg_idx_t rs1, reg_idx_t rs2);
        return '{vld: 1'b1, sid: sid, rd: rd, rs1: rs1, rs2: rs2};
    endfunction

    function automatic wb_lane_t wb_lane(sid_t sid, reg_idx_t rd);
        return '{vld: 1'b1, sid: sid, rd: rd};
    endfunction

    // all lanes idle at the falling edge
    task automatic next_cycle();
        @(negedge clk);
        dec_i      = '0;
        op_i       = '0;
        wb_i       = '0;
        redirect_i = '0;
    endtask

    task automatic reset_dut();
        rst_n = 1'b0;
        repeat (5) next_cycle();
        rst_n = 1'b1;
    endtask

    task automatic idle_after_reset();
        reset_dut();
        #1;
        check("stall and flush outputs", 32'({dec_stall_o, dec_flush_o, op_stall_o,
              op_flush_o, wb_stall_o, wb_flush_o}), 32'h0);
        check("dec_sid_o", 32'(dec_sid_o), 32'h10);
    endtask

    task automatic dual_alu_issue();
        reset_dut();
        dec_i[0] = dec_lane(UNIT_ALU, 5'd1);
        dec_i[1] = dec_lane(UNIT_ALU, 5'd2);
        #1;
        check("dec_stall_o", 32'(dec_stall_o), 32'h0);
        check("dec_grant_o", 32'(dec_grant_o), 32'h21);
        check("dec_sid_o", 32'(dec_sid_o), 32'h10);
        next_cycle();
        // both alu slots now busy
        dec_i[0] = dec_lane(UNIT_ALU, 5'd3);
        #1;
        check("dec_sid_o", 32'(dec_sid_o), 32'h32);
        check("dec_stall_o", 32'(dec_stall_o), 32'h1);
    endtask

    task automatic waw_stalls();
        reset_dut();
        dec_i[0] = dec_lane(UNIT_ALU, 5'd5);
        next_cycle();
        dec_i[0] = dec_lane(UNIT_BEU, 5'd5);
        #1;
        check("dec_stall_o", 32'(dec_stall_o), 32'h1);
        next_cycle();
        dec_i[0] = dec_lane(UNIT_ALU, 5'd9);
        dec_i[1] = dec_lane(UNIT_LSU, 5'd9);
        #1;
        check("dec_stall_o", 32'(dec_stall_o), 32'h2);
        check("dec_grant_o", 32'(dec_grant_o), 32'h02);
        next_cycle();
        dec_i[0] = dec_lane(UNIT_BEU, 5'd10);
        dec_i[1] = dec_lane(UNIT_LSU, 5'd11);
        #1;
        check("dec_stall_o", 32'(dec_stall_o), 32'h0);
        check("dec_grant_o", 32'(dec_grant_o), 32'h84);
    endtask

    task automatic raw_stalls();
        reset_dut();
        dec_i[0] = dec_lane(UNIT_ALU, 5'd3);
        next_cycle();
        op_i[0] = op_lane(4'd1, 5'd4, 5'd0, 5'd3);
        wb_i[0] = wb_lane(4'd0, 5'd3);
        #1;
        check("op_stall_o", 32'(op_stall_o), 32'h1);
        next_cycle();
        op_i[0] = op_lane(4'd1, 5'd4, 5'd0, 5'd3);
        #1;
        check("op_stall_o", 32'(op_stall_o), 32'h0);
        next_cycle();
        // each lane reads the other's rd
        op_i[0] = op_lane(4'd2, 5'd7, 5'd8, 5'd0);
        op_i[1] = op_lane(4'd3, 5'd8, 5'd7, 5'd0);
        #1;
        check("op_stall_o", 32'(op_stall_o), 32'h2);
    endtask

    task automatic wb_same_rd_order();
        reset_dut();
        dec_i[0] = dec_lane(UNIT_ALU, 5'd4);
        dec_i[1] = dec_lane(UNIT_BEU, 5'd6);
        next_cycle();
        // sid 1 is the younger writer of r4
        wb_i[0] = wb_lane(4'd1, 5'd4);
        wb_i[1] = wb_lane(4'd0, 5'd4);
        #1;
        check("wb_stall_o", 32'(wb_stall_o), 32'h1);
        next_cycle();
        dec_i[0] = dec_lane(UNIT_ALU, 5'd4);
        dec_i[1] = dec_lane(UNIT_LSU, 5'd6);
        #1;
        check("dec_stall_o", 32'(dec_stall_o), 32'h2);
        check("dec_grant_o", 32'(dec_grant_o), 32'h01);
    endtask

    task automatic redirect_flush();
        reset_dut();
        dec_i[0] = dec_lane(UNIT_ALU, 5'd1);
        dec_i[1] = dec_lane(UNIT_ALU, 5'd2);
        next_cycle();
        redirect_i = '{vld: 1'b1, sid: 4'd0};
        dec_i[0]   = dec_lane(UNIT_BEU, 5'd12);
        dec_i[1]   = dec_lane(UNIT_LSU, 5'd13);
        op_i[0]    = op_lane(4'd0, 5'd1, 5'd0, 5'd0);
        op_i[1]    = op_lane(4'd1, 5'd2, 5'd0, 5'd0);
        wb_i[0]    = wb_lane(4'd0, 5'd20);
        wb_i[1]    = wb_lane(4'd2, 5'd21);
        #1;
        check("dec_flush_o", 32'(dec_flush_o), 32'h3);
        check("op_flush_o", 32'(op_flush_o), 32'h2);
        check("wb_flush_o", 32'(wb_flush_o), 32'h2);
        next_cycle();
        // alu1 held r2 at sid 1 and was flushed
        dec_i[0] = dec_lane(UNIT_ALU, 5'd2);
        #1;
        check("dec_stall_o", 32'(dec_stall_o), 32'h0);
        check("dec_sid_o", 32'(dec_sid_o), 32'h32);
    endtask

    initial begin
        rst_n      = 1'b0;
        dec_i      = '0;
        op_i       = '0;
        wb_i       = '0;
        redirect_i = '0;
        idle_after_reset();
        dual_alu_issue();
        waw_stalls();
        raw_stalls();
        wb_same_rd_order();
        redirect_flush();
        $display("TESTBENCH PASSED");
        $finish;
    end

endmodule

//--- sim.f
design/scb_cfg_pkg.sv
design/scb_msg_pkg.sv
design/issue_ctrl.sv
design/slot_table.sv
design/operand_hazard.sv
design/wb_retire.sv
design/scoreboard_top.sv
test/scoreboard_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the scoreboard testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BUILD_DIR=obj_dir

verilator --binary --timing -j 0 --top-module scoreboard_tb \
    -Mdir "$BUILD_DIR" -o scoreboard_sim -f sim.f
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

"./$BUILD_DIR/scoreboard_sim" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"

if grep -q "TESTBENCH FAILED" "$LOG"; then
    exit 1
fi
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi
exit 0
